/* files.f */
hdl/debug_pkg.sv
hdl/debug_mailbox.sv
hdl/debug_ctrl.sv
hdl/debug_target.sv
hdl/debug_top.sv
testbench/debug_tb_assert.sv
testbench/debug_tb.sv

/* Makefile */
SRCS := $(shell cat files.f)

obj_dir/Vdebug_tb: files.f $(SRCS)
	verilator --binary --timing --assert --top-module debug_tb -f files.f -o Vdebug_tb

run: obj_dir/Vdebug_tb
	./obj_dir/Vdebug_tb 2>&1 | tee sim.log
	grep -q "Verification passed" sim.log
	! grep -q "Verification failed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* testbench/debug_tb.sv */
`timescale 1ns/10ps

module debug_tb
	import debug_pkg::*;
();

	localparam int icache_lines = 32;
	localparam word_t bkpt_pc = 32'h100;
	localparam int ack_timeout = 1000;
	localparam int status_polls = 20;

	logic clk;
	logic rst;
	mbox_addr_t addr;
	word_t din;
	word_t dout;
	logic wr_en;
	logic req;
	logic ack;
	logic [$clog2(icache_lines)-1:0] icache_idx;
	logic icache_inval;

	int errors;
	int cycle = 0;
	int ack_cycle;

	debug_top i_debug_top (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.din(din),
		.dout(dout),
		.wr_en(wr_en),
		.req(req),
		.ack(ack),
		.icache_idx(icache_idx),
		.icache_inval(icache_inval)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		assert (actual === expected) else begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// called on a falling edge, returns on the next one
	task automatic mbox_write(input mbox_addr_t a, input word_t d);
		addr = a;
		din = d;
		wr_en = 1'b1;
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	task automatic run_cmd(input string name, input debug_cmd_t cmd, input word_t a,
			input word_t d, output word_t result);
		int n;
		mbox_write(mbox_cmd, 32'(cmd));
		mbox_write(mbox_addr, a);
		mbox_write(mbox_data, d);
		addr = mbox_result;
		req = 1'b1;
		n = 0;
		while (!ack && n < ack_timeout) begin
			@(negedge clk);
			n++;
		end
		if (!ack) begin
			errors++;
			$display("%s: timed out waiting for ack", name);
		end
		ack_cycle = cycle;
		result = dout;
		req = 1'b0;
		n = 0;
		while (ack && n < ack_timeout) begin
			@(negedge clk);
			n++;
		end
		if (ack) begin
			errors++;
			$display("%s: ack stayed high after req was dropped", name);
		end
	endtask

	task automatic reg_roundtrip(input string name, input word_t a, input word_t value);
		word_t result;
		run_cmd(name, cmd_write_reg, a, value, result);
		run_cmd(name, cmd_read_reg, a, '0, result);
		check_value(name, value, result);
	endtask

	initial begin
		word_t result;
		word_t value;
		word_t mem_base;
		word_t merged;
		word_t pc_halt;
		word_t bound;
		int byte_off;
		int half_off;
		int reset_ack;
		int polls;
		int i;

		rst = 1'b1;
		addr = '0;
		din = '0;
		wr_en = 1'b0;
		req = 1'b0;
		errors = 0;
		void'($urandom(32'h32f7_9d95));
		repeat (4) @(negedge clk);
		rst = 1'b0;

		// registers and pc, core halted
		run_cmd("halt", cmd_halt, '0, '0, result);
		reg_roundtrip("gpr", $urandom & 32'hf, $urandom);
		reg_roundtrip("cr", 32'h20 | ($urandom & 32'h7), $urandom);
		reg_roundtrip("pc", 32'h10, 32'h1000 | ($urandom & 32'hffc));

		// memory lanes
		mem_base = ($urandom % 64) * 4;
		merged = $urandom;
		run_cmd("wmem32", cmd_wmem32, mem_base, merged, result);
		byte_off = $urandom % 4;
		value = $urandom;
		run_cmd("wmem8", cmd_wmem8, mem_base + byte_off, value, result);
		merged[8*byte_off +: 8] = value[7:0];
		half_off = $urandom % 2;
		value = $urandom;
		run_cmd("wmem16", cmd_wmem16, mem_base + 2 * half_off, value, result);
		merged[16*half_off +: 16] = value[15:0];
		run_cmd("rmem32", cmd_rmem32, mem_base, '0, result);
		check_value("rmem32", merged, result);
		half_off = $urandom % 2;
		run_cmd("rmem16", cmd_rmem16, mem_base + 2 * half_off, '0, result);
		check_value("rmem16", {16'b0, merged[16*half_off +: 16]}, result);
		byte_off = $urandom % 4;
		run_cmd("rmem8", cmd_rmem8, mem_base + byte_off, '0, result);
		check_value("rmem8", {24'b0, merged[8*byte_off +: 8]}, result);

		// halt, step, breakpoint
		run_cmd("run", cmd_run, '0, '0, result);
		run_cmd("halt_pc", cmd_halt, '0, '0, pc_halt);
		check_value("halt_pc_align", 32'd0, pc_halt & 32'd3);
		run_cmd("step", cmd_step, '0, '0, result);
		check_value("step_pc", pc_halt + 32'd4, result);
		run_cmd("halt", cmd_halt, '0, '0, result);
		run_cmd("status_halted", cmd_get_exec_status, '0, '0, result);
		check_value("status_halted", 32'd0, result);
		run_cmd("write_pc", cmd_write_reg, 32'h10, bkpt_pc - 32'd8, result);
		run_cmd("run", cmd_run, '0, '0, result);
		polls = 0;
		result = '0;
		while (result != 32'd2 && polls < status_polls) begin
			run_cmd("status_bkpt", cmd_get_exec_status, '0, '0, result);
			polls++;
		end
		check_value("status_bkpt", 32'd2, result);
		check_value("status_bkpt_bit", 32'd1, {31'b0, result[1]});

		for (i = 0; i < 8; i++) begin
			run_cmd("cpuid", cmd_cpuid, i, '0, result);
			check_value($sformatf("cpuid%0d", i), cpuid_table[i], result);
		end

		// pc can only have moved since the reset ack
		run_cmd("run", cmd_run, '0, '0, result);
		run_cmd("reset", cmd_reset, '0, '0, result);
		reset_ack = ack_cycle;
		run_cmd("halt_after_reset", cmd_halt, '0, '0, result);
		bound = 4 * (ack_cycle - reset_ack);
		assert (result <= bound) else begin
			errors++;
			$display("Error halt_after_reset: expected at most %h, actual %h", bound, result);
		end

		run_cmd("cache_sync", cmd_cache_sync, '0, '0, result);
		check_value("cache_sync_idx", 32'(icache_lines - 1), 32'(icache_idx));

		repeat (4) @(negedge clk);
		$display("%0d errors, %0d assertion failures", errors,
			i_debug_top.i_debug_tb_assert.fail_count);
		if (errors == 0 && i_debug_top.i_debug_tb_assert.fail_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* testbench/debug_tb_assert.sv */
`timescale 1ns/10ps

module debug_tb_assert
	import debug_pkg::*;
#(
	parameter int icache_lines = 32
) (
	input logic clk,
	input logic rst,
	input logic wr_en,
	input logic req,
	input logic ack,
	input logic ctl_wr_en,
	input logic reg_wr_en,
	input logic cr_wr_en,
	input logic pc_wr_en,
	input logic mem_wr_en,
	input logic mem_access,
	input logic mem_compl,
	input logic core_rst,
	input logic [$clog2(icache_lines)-1:0] icache_idx,
	input logic icache_inval
);

	int fail_count = 0;
	int core_rst_len;

	// length of the current core reset pulse
	always_ff @(posedge clk) begin
		if (rst || !core_rst)
			core_rst_len <= 0;
		else
			core_rst_len <= core_rst_len + 1;
	end

	ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |-> $past(req))
		else begin
			fail_count++;
			$error("ack rose while req was low");
		end

	mem_access_pulse: assert property (@(posedge clk) disable iff (rst)
		mem_access |=> !mem_access)
		else begin
			fail_count++;
			$error("mem_access held for more than one cycle");
		end

	mem_compl_delay: assert property (@(posedge clk) disable iff (rst)
		mem_compl == $past(mem_access, 2))
		else begin
			fail_count++;
			$error("mem_compl not two cycles after mem_access");
		end

	// sweep starts at 0, counts up by one and ends on the last line
	sweep_start: assert property (@(posedge clk) disable iff (rst)
		$rose(icache_inval) |-> icache_idx == '0)
		else begin
			fail_count++;
			$error("cache sweep did not start at index 0");
		end

	sweep_step: assert property (@(posedge clk) disable iff (rst)
		icache_inval && $past(icache_inval) |-> icache_idx == $past(icache_idx) + 1'b1)
		else begin
			fail_count++;
			$error("cache sweep index did not increment");
		end

	sweep_end: assert property (@(posedge clk) disable iff (rst)
		$fell(icache_inval) |-> &$past(icache_idx))
		else begin
			fail_count++;
			$error("cache sweep ended before the last line");
		end

	core_rst_length: assert property (@(posedge clk) disable iff (rst)
		$fell(core_rst) |-> core_rst_len == reset_cycles)
		else begin
			fail_count++;
			$error("core reset pulse has the wrong length");
		end

	quiet_during_ack: assert property (@(posedge clk) disable iff (rst)
		ack |-> !(wr_en || ctl_wr_en || reg_wr_en || cr_wr_en || pc_wr_en || mem_wr_en))
		else begin
			fail_count++;
			$error("write enable active while ack is high");
		end

endmodule

bind debug_top debug_tb_assert #(
	.icache_lines(icache_lines)
) i_debug_tb_assert (
	.clk(clk),
	.rst(rst),
	.wr_en(wr_en),
	.req(req),
	.ack(ack),
	.ctl_wr_en(ctl_wr_en),
	.reg_wr_en(reg_wr_en),
	.cr_wr_en(cr_wr_en),
	.pc_wr_en(pc_wr_en),
	.mem_wr_en(mem_wr_en),
	.mem_access(mem_access),
	.mem_compl(mem_compl),
	.core_rst(core_rst),
	.icache_idx(icache_idx),
	.icache_inval(icache_inval)
);

/* hdl/debug_top.sv */
`timescale 1ns/10ps

module debug_top
	import debug_pkg::*;
#(
	parameter int icache_lines = 32,
	parameter int mem_words = 64,
	parameter word_t bkpt_pc = 32'h100
) (
	input logic clk,
	input logic rst,
	input mbox_addr_t addr,
	input word_t din,
	output word_t dout,
	input logic wr_en,
	input logic req,
	output logic ack,
	output logic [$clog2(icache_lines)-1:0] icache_idx,
	output logic icache_inval
);

	mbox_addr_t ctl_addr;
	word_t ctl_din;
	word_t ctl_dout;
	logic ctl_wr_en;
	logic run;
	logic stopped;
	logic bkpt_hit;
	reg_sel_t reg_sel;
	cr_sel_t cr_sel;
	cr_sel_t cpuid_sel;
	word_t reg_wr_val;
	logic reg_wr_en;
	logic cr_wr_en;
	logic pc_wr_en;
	word_t reg_val;
	word_t cr_val;
	word_t pc;
	word_t cpuid_val;
	word_t mem_addr;
	mem_width_t mem_width;
	word_t mem_wr_val;
	logic mem_wr_en;
	logic mem_access;
	word_t mem_rd_val;
	logic mem_compl;
	logic core_rst;

	debug_mailbox i_debug_mailbox (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.din(din),
		.dout(dout),
		.wr_en(wr_en),
		.ctl_addr(ctl_addr),
		.ctl_din(ctl_din),
		.ctl_dout(ctl_dout),
		.ctl_wr_en(ctl_wr_en)
	);

	debug_ctrl #(
		.icache_lines(icache_lines)
	) i_debug_ctrl (
		.clk(clk),
		.rst(rst),
		.req(req),
		.ack(ack),
		.ctl_addr(ctl_addr),
		.ctl_din(ctl_din),
		.ctl_dout(ctl_dout),
		.ctl_wr_en(ctl_wr_en),
		.run(run),
		.stopped(stopped),
		.bkpt_hit(bkpt_hit),
		.reg_sel(reg_sel),
		.cr_sel(cr_sel),
		.cpuid_sel(cpuid_sel),
		.reg_wr_val(reg_wr_val),
		.reg_wr_en(reg_wr_en),
		.cr_wr_en(cr_wr_en),
		.pc_wr_en(pc_wr_en),
		.reg_val(reg_val),
		.cr_val(cr_val),
		.pc(pc),
		.mem_addr(mem_addr),
		.mem_width(mem_width),
		.mem_wr_val(mem_wr_val),
		.mem_wr_en(mem_wr_en),
		.mem_access(mem_access),
		.mem_rd_val(mem_rd_val),
		.mem_compl(mem_compl),
		.core_rst(core_rst),
		.icache_idx(icache_idx),
		.icache_inval(icache_inval),
		.cpuid_val(cpuid_val)
	);

	debug_target #(
		.mem_words(mem_words),
		.bkpt_pc(bkpt_pc)
	) i_debug_target (
		.clk(clk),
		.rst(rst),
		.run(run),
		.core_rst(core_rst),
		.stopped(stopped),
		.bkpt_hit(bkpt_hit),
		.reg_sel(reg_sel),
		.cr_sel(cr_sel),
		.cpuid_sel(cpuid_sel),
		.reg_wr_val(reg_wr_val),
		.reg_wr_en(reg_wr_en),
		.cr_wr_en(cr_wr_en),
		.pc_wr_en(pc_wr_en),
		.reg_val(reg_val),
		.cr_val(cr_val),
		.pc(pc),
		.cpuid_val(cpuid_val),
		.mem_addr(mem_addr),
		.mem_width(mem_width),
		.mem_wr_val(mem_wr_val),
		.mem_wr_en(mem_wr_en),
		.mem_access(mem_access),
		.mem_rd_val(mem_rd_val),
		.mem_compl(mem_compl)
	);

endmodule

/* hdl/debug_target.sv */
`timescale 1ns/10ps

module debug_target
	import debug_pkg::*;
#(
	parameter int mem_words = 64,
	parameter word_t bkpt_pc = 32'h100
) (
	input logic clk,
	input logic rst,
	input logic run,
	input logic core_rst,
	output logic stopped,
	output logic bkpt_hit,
	input reg_sel_t reg_sel,
	input cr_sel_t cr_sel,
	input cr_sel_t cpuid_sel,
	input word_t reg_wr_val,
	input logic reg_wr_en,
	input logic cr_wr_en,
	input logic pc_wr_en,
	output word_t reg_val,
	output word_t cr_val,
	output word_t pc,
	output word_t cpuid_val,
	input word_t mem_addr,
	input mem_width_t mem_width,
	input word_t mem_wr_val,
	input logic mem_wr_en,
	input logic mem_access,
	output word_t mem_rd_val,
	output logic mem_compl
);

	localparam int mem_idx_bits = $clog2(mem_words);

	word_t gpr [16];
	word_t cr [8];
	word_t mem [mem_words];
	logic eff_run;
	logic acc_q;
	logic compl_q;
	logic wr_q;
	mem_width_t width_q;
	word_t addr_q;
	word_t wr_val_q;
	word_t rd_q;
	word_t mem_word;
	word_t lane_data;
	logic [3:0] lane_en;
	logic [mem_idx_bits-1:0] mem_idx;

	assign eff_run = run && !core_rst;
	// stopped is last cycle's state, so resuming from bkpt_pc moves on
	assign bkpt_hit = !stopped && !core_rst && pc == bkpt_pc;

	assign reg_val = gpr[reg_sel];
	assign cr_val = cr[cr_sel];
	assign cpuid_val = cpuid_table[cpuid_sel];

	always_ff @(posedge clk) begin
		if (rst) begin
			stopped <= 1'b1;
			pc <= '0;
		end else begin
			stopped <= !eff_run;
			if (core_rst)
				pc <= '0;
			else if (pc_wr_en)
				pc <= reg_wr_val;
			else if (eff_run)
				pc <= pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || core_rst) begin
			for (int i = 0; i < 16; i++)
				gpr[i] <= '0;
			for (int i = 0; i < 8; i++)
				cr[i] <= '0;
		end else begin
			if (reg_wr_en)
				gpr[reg_sel] <= reg_wr_val;
			if (cr_wr_en)
				cr[cr_sel] <= reg_wr_val;
		end
	end

	// strobe, then access, then completion
	always_ff @(posedge clk) begin
		if (rst) begin
			acc_q <= 1'b0;
			compl_q <= 1'b0;
		end else begin
			acc_q <= mem_access;
			compl_q <= acc_q;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_access) begin
			addr_q <= mem_addr;
			width_q <= mem_width;
			wr_q <= mem_wr_en;
			wr_val_q <= mem_wr_val;
		end
	end

	assign mem_idx = addr_q[mem_idx_bits+1:2];
	assign mem_word = mem[mem_idx];

	always_comb begin
		case (width_q)
		width_byte: begin
			lane_en = 4'b0001 << addr_q[1:0];
			lane_data = {4{wr_val_q[7:0]}};
		end
		width_half: begin
			lane_en = addr_q[1] ? 4'b1100 : 4'b0011;
			lane_data = {2{wr_val_q[15:0]}};
		end
		default: begin
			lane_en = 4'b1111;
			lane_data = wr_val_q;
		end
		endcase
	end

	always_ff @(posedge clk) begin
		if (acc_q) begin
			if (wr_q) begin
				for (int i = 0; i < 4; i++)
					if (lane_en[i])
						mem[mem_idx][8*i +: 8] <= lane_data[8*i +: 8];
			end
			case (width_q)
			width_byte: rd_q <= {24'b0, mem_word[{addr_q[1:0], 3'b000} +: 8]};
			width_half: rd_q <= {16'b0, mem_word[{addr_q[1], 4'b0000} +: 16]};
			default: rd_q <= mem_word;
			endcase
		end
	end

	assign mem_rd_val = rd_q;
	assign mem_compl = compl_q;

endmodule

/* hdl/debug_ctrl.sv */
`timescale 1ns/10ps

module debug_ctrl
	import debug_pkg::*;
#(
	parameter int icache_lines = 32
) (
	input logic clk,
	input logic rst,
	input logic req,
	output logic ack,
	// mailbox
	output mbox_addr_t ctl_addr,
	output word_t ctl_din,
	input word_t ctl_dout,
	output logic ctl_wr_en,
	// execution control
	output logic run,
	input logic stopped,
	input logic bkpt_hit,
	// registers and pc
	output reg_sel_t reg_sel,
	output cr_sel_t cr_sel,
	output cr_sel_t cpuid_sel,
	output word_t reg_wr_val,
	output logic reg_wr_en,
	output logic cr_wr_en,
	output logic pc_wr_en,
	input word_t reg_val,
	input word_t cr_val,
	input word_t pc,
	// memory
	output word_t mem_addr,
	output mem_width_t mem_width,
	output word_t mem_wr_val,
	output logic mem_wr_en,
	output logic mem_access,
	input word_t mem_rd_val,
	input logic mem_compl,
	// reset, cache, cpuid
	output logic core_rst,
	output logic [$clog2(icache_lines)-1:0] icache_idx,
	output logic icache_inval,
	input word_t cpuid_val
);

	typedef enum logic [3:0] {
		s_idle, s_load_cmd, s_load_addr, s_load_data, s_execute,
		s_wait_stopped, s_step, s_write_reg, s_store_reg,
		s_wait_rmem, s_wait_wmem, s_reset, s_cache_sync, s_compl
	} ctrl_state_t;

	ctrl_state_t state;
	ctrl_state_t next_state;
	debug_cmd_t debug_cmd;
	word_t debug_addr;
	word_t debug_data;
	logic [7:0] reset_count;
	logic do_run;
	logic stopped_on_bkpt;
	logic is_mem_wr;

	// a breakpoint stops the core in the same cycle
	assign run = do_run && !bkpt_hit;
	assign ack = state == s_compl;
	assign core_rst = state == s_reset;
	assign icache_inval = state == s_cache_sync;

	assign reg_sel = debug_addr[3:0];
	assign cr_sel = debug_addr[2:0];
	assign cpuid_sel = debug_addr[2:0];
	assign reg_wr_val = debug_data;
	assign mem_addr = debug_addr;
	assign mem_wr_val = debug_data;
	assign mem_wr_en = mem_access && is_mem_wr;

	always_comb begin
		is_mem_wr = 1'b0;
		mem_width = width_word;
		case (debug_cmd)
		cmd_rmem16: mem_width = width_half;
		cmd_rmem8: mem_width = width_byte;
		cmd_wmem32: is_mem_wr = 1'b1;
		cmd_wmem16: begin
			mem_width = width_half;
			is_mem_wr = 1'b1;
		end
		cmd_wmem8: begin
			mem_width = width_byte;
			is_mem_wr = 1'b1;
		end
		default: ;
		endcase
	end

	always_comb begin
		next_state = state;
		ctl_addr = mbox_cmd;
		ctl_din = '0;
		ctl_wr_en = 1'b0;
		reg_wr_en = 1'b0;
		cr_wr_en = 1'b0;
		pc_wr_en = 1'b0;
		mem_access = 1'b0;

		case (state)
		s_idle: if (req) next_state = s_load_cmd;
		s_load_cmd: next_state = s_load_addr;
		s_load_addr: begin
			ctl_addr = mbox_addr;
			next_state = s_load_data;
		end
		s_load_data: begin
			ctl_addr = mbox_data;
			next_state = s_execute;
		end
		s_execute: begin
			case (debug_cmd)
			cmd_halt: next_state = s_wait_stopped;
			cmd_step: next_state = s_step;
			cmd_write_reg: next_state = s_write_reg;
			cmd_read_reg, cmd_cpuid, cmd_get_exec_status: next_state = s_store_reg;
			cmd_rmem32, cmd_rmem16, cmd_rmem8: begin
				mem_access = 1'b1;
				next_state = s_wait_rmem;
			end
			cmd_wmem32, cmd_wmem16, cmd_wmem8: begin
				mem_access = 1'b1;
				next_state = s_wait_wmem;
			end
			cmd_reset: next_state = s_reset;
			cmd_cache_sync: next_state = s_cache_sync;
			default: next_state = s_compl;
			endcase
		end
		s_step: next_state = s_wait_stopped;
		s_wait_stopped: begin
			if (stopped) begin
				ctl_addr = mbox_result;
				ctl_wr_en = 1'b1;
				ctl_din = pc;
				next_state = s_compl;
			end
		end
		s_write_reg: begin
			if (debug_addr[4])
				pc_wr_en = 1'b1;
			else if (debug_addr[5])
				cr_wr_en = 1'b1;
			else
				reg_wr_en = 1'b1;
			next_state = s_compl;
		end
		s_store_reg: begin
			ctl_addr = mbox_result;
			ctl_wr_en = 1'b1;
			case (debug_cmd)
			cmd_cpuid: ctl_din = cpuid_val;
			cmd_get_exec_status: ctl_din = {30'b0, stopped_on_bkpt, run};
			default: ctl_din = debug_addr[4] ? pc : debug_addr[5] ? cr_val : reg_val;
			endcase
			next_state = s_compl;
		end
		s_wait_rmem: begin
			if (mem_compl) begin
				ctl_addr = mbox_result;
				ctl_wr_en = 1'b1;
				ctl_din = mem_rd_val;
				next_state = s_compl;
			end
		end
		s_wait_wmem: if (mem_compl) next_state = s_compl;
		s_reset: if (reset_count == 8'd1) next_state = s_compl;
		s_cache_sync: if (&icache_idx) next_state = s_compl;
		s_compl: if (!req) next_state = s_idle;
		default: next_state = s_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= s_idle;
			debug_cmd <= cmd_halt;
			do_run <= 1'b1;
			stopped_on_bkpt <= 1'b0;
			reset_count <= '0;
			icache_idx <= '1;
		end else begin
			state <= next_state;
			if (do_run && bkpt_hit)
				do_run <= 1'b0;
			if (bkpt_hit)
				stopped_on_bkpt <= 1'b1;
			else if (stopped_on_bkpt && run)
				stopped_on_bkpt <= 1'b0;

			case (state)
			// unknown codes map to 15, which completes with no action
			s_load_cmd: debug_cmd <= debug_cmd_t'(|ctl_dout[31:4] ? 4'hf : ctl_dout[3:0]);
			s_execute: begin
				reset_count <= 8'(reset_cycles);
				case (debug_cmd)
				cmd_halt: do_run <= 1'b0;
				cmd_run, cmd_step: do_run <= 1'b1;
				cmd_cache_sync: icache_idx <= '0;
				default: ;
				endcase
			end
			// one cycle of run for a step
			s_step: do_run <= 1'b0;
			s_reset: reset_count <= reset_count - 8'd1;
			s_cache_sync: if (!(&icache_idx)) icache_idx <= icache_idx + 1'b1;
			default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == s_load_addr)
			debug_addr <= ctl_dout;
		if (state == s_load_data)
			debug_data <= ctl_dout;
	end

endmodule

/* hdl/debug_mailbox.sv */
`timescale 1ns/10ps

module debug_mailbox
	import debug_pkg::*;
(
	input logic clk,
	input logic rst,
	// host port
	input mbox_addr_t addr,
	input word_t din,
	output word_t dout,
	input logic wr_en,
	// controller port
	input mbox_addr_t ctl_addr,
	input word_t ctl_din,
	output word_t ctl_dout,
	input logic ctl_wr_en
);

	word_t words [4];

	assign dout = words[addr];
	assign ctl_dout = words[ctl_addr];

	// the protocol keeps the two ports on different words in any cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 4; i++) begin
				words[i] <= '0;
			end
		end else begin
			if (wr_en) begin
				words[addr] <= din;
			end
			if (ctl_wr_en) begin
				words[ctl_addr] <= ctl_din;
			end
		end
	end

endmodule

/* hdl/debug_pkg.sv */
package debug_pkg;

	typedef logic [31:0] word_t;
	typedef logic [1:0] mbox_addr_t;
	typedef logic [1:0] mem_width_t;
	typedef logic [3:0] reg_sel_t;
	typedef logic [2:0] cr_sel_t;

	// host command codes, word 0 of the mailbox
	typedef enum logic [3:0] {
		cmd_halt = 4'd0,
		cmd_run = 4'd1,
		cmd_step = 4'd2,
		cmd_read_reg = 4'd3,
		cmd_write_reg = 4'd4,
		cmd_rmem32 = 4'd5,
		cmd_rmem16 = 4'd6,
		cmd_rmem8 = 4'd7,
		cmd_wmem32 = 4'd8,
		cmd_wmem16 = 4'd9,
		cmd_wmem8 = 4'd10,
		cmd_reset = 4'd11,
		cmd_cache_sync = 4'd12,
		cmd_cpuid = 4'd13,
		cmd_get_exec_status = 4'd14
	} debug_cmd_t;

	localparam mbox_addr_t mbox_cmd = 2'd0;
	localparam mbox_addr_t mbox_addr = 2'd1;
	localparam mbox_addr_t mbox_data = 2'd2;
	localparam mbox_addr_t mbox_result = 2'd3;

	localparam mem_width_t width_byte = 2'd0;
	localparam mem_width_t width_half = 2'd1;
	localparam mem_width_t width_word = 2'd2;

	// version, feature bits, cache and memory geometry
	localparam word_t cpuid_table [8] = '{
		32'h0001_0002, 32'h0000_001f, 32'h0000_0100, 32'h0020_0020,
		32'h0000_0040, 32'h0000_0000, 32'h8000_0000, 32'hd0b6_0001
	};

	localparam int reset_cycles = 255;

endpackage
